// File: flist.f
+incdir+hdl
hdl/vga_mem_pkg.sv
hdl/vga_c4_iface.sv
hdl/vga_scan_fetch.sv
hdl/vga_mem_arbiter.sv
hdl/vga_sram.sv
hdl/vga_mem_top.sv
bench/vga_mem_sva.sv
bench/vga_mem_tb.sv

// File: Bender.yml
package:
  name: vga_mem

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/vga_mem_pkg.sv
      - hdl/vga_c4_iface.sv
      - hdl/vga_scan_fetch.sv
      - hdl/vga_mem_arbiter.sv
      - hdl/vga_sram.sv
      - hdl/vga_mem_top.sv
  - target: test
    files:
      - bench/vga_mem_sva.sv
      - bench/vga_mem_tb.sv

// File: bench/vga_mem_tb.sv
module vga_mem_tb;

  // Test sizes
  localparam int N_WORDS     = 16;
  localparam int N_PART      = 8;
  localparam int N_ALIAS     = 4;
  localparam int N_MIXED     = 12;
  localparam int LINE_A_LEN  = 40;
  localparam int LINE_B_LEN  = 48;
  localparam int LINE_A_BASE = 16'h1235;
  localparam int LINE_B_BASE = 16'h2001;
  // CPU words touched while the second line is on screen
  localparam int MIXED_WORD  = 16'h3000;
  localparam int ACK_LIMIT   = 40;

  // Line fill needs at most len/2 + 1 word writes
  localparam int CPU_ACCESSES = 2 * N_WORDS + 3 * N_PART + 4 * N_ALIAS +
                                (LINE_A_LEN / 2 + 1) + (LINE_B_LEN / 2 + 1) + 3 * N_MIXED;
  localparam int PIXELS      = LINE_A_LEN + LINE_B_LEN;
  localparam int CYCLE_LIMIT = 40 * CPU_ACCESSES + 8 * PIXELS;

  logic                   wb_clk_i = 1'b0;
  logic                   rst_i;
  vga_mem_pkg::cpu_adr_t  wbs_adr_i;
  vga_mem_pkg::bus_sel_t  wbs_sel_i;
  logic                   wbs_we_i;
  vga_mem_pkg::bus_dat_t  wbs_dat_i;
  logic                   wbs_stb_i;
  vga_mem_pkg::bus_dat_t  wbs_dat_o;
  logic                   wbs_ack_o;
  logic                   line_start_i;
  vga_mem_pkg::cpu_adr_t  line_base_i;
  vga_mem_pkg::line_len_t line_len_i;
  vga_mem_pkg::pix_t      pix_dat_o;
  logic                   pix_vld_o;
  logic                   pix_rdy_i;
  logic                   busy_o;

  int          checks;
  int          value_errs;
  int          other_errs;
  int          cycle_cnt;
  int unsigned seed_val;

  // CPU byte space after the 64K fold
  vga_mem_pkg::pix_t model_mem [65536];

  vga_mem_top u_vga_mem_top (
    .wb_clk_i     (wb_clk_i),
    .rst_i        (rst_i),
    .wbs_adr_i    (wbs_adr_i),
    .wbs_sel_i    (wbs_sel_i),
    .wbs_we_i     (wbs_we_i),
    .wbs_dat_i    (wbs_dat_i),
    .wbs_stb_i    (wbs_stb_i),
    .wbs_dat_o    (wbs_dat_o),
    .wbs_ack_o    (wbs_ack_o),
    .line_start_i (line_start_i),
    .line_base_i  (line_base_i),
    .line_len_i   (line_len_i),
    .pix_dat_o    (pix_dat_o),
    .pix_vld_o    (pix_vld_o),
    .pix_rdy_i    (pix_rdy_i),
    .busy_o       (busy_o)
  );

  always #5 wb_clk_i = ~wb_clk_i;

  // Byte address is word address plus lane, taken mod 64K
  function automatic vga_mem_pkg::cpu_adr_t byte_index(vga_mem_pkg::cpu_adr_t adr,
                                                      logic lane);
    logic [16:0] b;
    b = {adr, lane};
    return b[15:0];
  endfunction

  function automatic vga_mem_pkg::bus_dat_t model_word(vga_mem_pkg::cpu_adr_t adr);
    return {model_mem[byte_index(adr, 1'b1)], model_mem[byte_index(adr, 1'b0)]};
  endfunction

  task automatic check_word(input string name, input vga_mem_pkg::bus_dat_t exp,
                            input vga_mem_pkg::bus_dat_t act);
    checks++;
    if (act !== exp) begin
      value_errs++;
      $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_pix(input string name, input vga_mem_pkg::pix_t exp,
                           input vga_mem_pkg::pix_t act);
    checks++;
    if (act !== exp) begin
      value_errs++;
      $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
    end
  endtask

  // One classic Wishbone cycle, stb held until ack
  task automatic cpu_access(input vga_mem_pkg::cpu_adr_t adr, input vga_mem_pkg::bus_sel_t sel,
                            input logic we, input vga_mem_pkg::bus_dat_t dat,
                            output vga_mem_pkg::bus_dat_t rdat);
    int waited;
    waited = 0;
    rdat   = '0;
    @(negedge wb_clk_i);
    wbs_adr_i = adr;
    wbs_sel_i = sel;
    wbs_we_i  = we;
    wbs_dat_i = dat;
    wbs_stb_i = 1'b1;
    do begin
      @(negedge wb_clk_i);
      waited++;
    end while (!wbs_ack_o && waited < ACK_LIMIT);
    if (wbs_ack_o) begin
      rdat = wbs_dat_o;
    end else begin
      other_errs++;
      $display("No wbs_ack_o within %0d cycles for address %h", ACK_LIMIT, adr);
    end
    wbs_stb_i = 1'b0;
    wbs_we_i  = 1'b0;
  endtask

  task automatic cpu_write(input vga_mem_pkg::cpu_adr_t adr, input vga_mem_pkg::bus_sel_t sel,
                           input vga_mem_pkg::bus_dat_t dat);
    vga_mem_pkg::bus_dat_t unused;
    cpu_access(adr, sel, 1'b1, dat, unused);
    // Only selected lanes land
    if (sel[0]) begin
      model_mem[byte_index(adr, 1'b0)] = dat[7:0];
    end
    if (sel[1]) begin
      model_mem[byte_index(adr, 1'b1)] = dat[15:8];
    end
  endtask

  task automatic read_and_check(input string name, input vga_mem_pkg::cpu_adr_t adr);
    vga_mem_pkg::bus_dat_t rdat;
    cpu_access(adr, 2'b11, 1'b0, '0, rdat);
    check_word(name, model_word(adr), rdat);
  endtask

  // Whole words covering a byte range
  task automatic fill_region(input vga_mem_pkg::cpu_adr_t base, input int len);
    vga_mem_pkg::cpu_adr_t last;
    int                    w;
    last = vga_mem_pkg::cpu_adr_t'(base + len - 1);
    for (w = int'(base >> 1); w <= int'(last >> 1); w++) begin
      cpu_write(vga_mem_pkg::cpu_adr_t'(w), 2'b11, vga_mem_pkg::bus_dat_t'($urandom));
    end
  endtask

  // Start a line and take its pixels under random back-pressure
  task automatic scan_line(input string name, input vga_mem_pkg::cpu_adr_t base,
                           input int len);
    vga_mem_pkg::cpu_adr_t bidx;
    logic                  rdy;
    int                    k;
    int                    cycles;
    k      = 0;
    cycles = 0;
    @(negedge wb_clk_i);
    line_base_i  = base;
    line_len_i   = vga_mem_pkg::line_len_t'(len);
    line_start_i = 1'b1;
    @(negedge wb_clk_i);
    line_start_i = 1'b0;
    while (k < len) begin
      if (!busy_o) begin
        other_errs++;
        $display("%s: busy_o low with %0d of %0d pixels taken", name, k, len);
        break;
      end
      rdy       = ($urandom % 3) != 0;
      pix_rdy_i = rdy;
      // Pixel is taken at the coming rising edge
      if (pix_vld_o && rdy) begin
        bidx = vga_mem_pkg::cpu_adr_t'(base + k);
        check_pix($sformatf("%s pixel %0d", name, k), model_mem[bidx], pix_dat_o);
        k++;
      end
      @(negedge wb_clk_i);
      cycles++;
      if (cycles > 8 * len + 40) begin
        other_errs++;
        $display("%s: only %0d of %0d pixels arrived", name, k, len);
        break;
      end
    end
    pix_rdy_i = 1'b0;
    if (busy_o || pix_vld_o) begin
      other_errs++;
      $display("%s: busy_o or pix_vld_o still high after the last pixel", name);
    end
  endtask

  task automatic idle_after_reset();
    repeat (8) begin
      @(negedge wb_clk_i);
      if (wbs_ack_o || pix_vld_o || busy_o) begin
        other_errs++;
        $display("Outputs active after reset: ack %b vld %b busy %b",
                 wbs_ack_o, pix_vld_o, busy_o);
      end
    end
  endtask

  task automatic word_readback();
    vga_mem_pkg::cpu_adr_t adrs [N_WORDS];
    for (int i = 0; i < N_WORDS; i++) begin
      adrs[i] = vga_mem_pkg::cpu_adr_t'($urandom);
      cpu_write(adrs[i], 2'b11, vga_mem_pkg::bus_dat_t'($urandom));
    end
    for (int i = 0; i < N_WORDS; i++) begin
      read_and_check($sformatf("word_readback %0d", i), adrs[i]);
    end
  endtask

  task automatic partial_write_lanes();
    vga_mem_pkg::cpu_adr_t adr;
    vga_mem_pkg::bus_sel_t sel;
    for (int i = 0; i < N_PART; i++) begin
      adr = vga_mem_pkg::cpu_adr_t'($urandom);
      sel = ($urandom % 2) ? 2'b10 : 2'b01;
      cpu_write(adr, 2'b11, vga_mem_pkg::bus_dat_t'($urandom));
      cpu_write(adr, sel, vga_mem_pkg::bus_dat_t'($urandom));
      read_and_check($sformatf("partial_write_lanes %0d sel %b", i, sel), adr);
    end
  endtask

  // Word address bit 15 is byte address bit 16
  task automatic bit16_aliasing();
    vga_mem_pkg::cpu_adr_t adr;
    vga_mem_pkg::bus_dat_t d_late;
    vga_mem_pkg::bus_dat_t rdat;
    for (int i = 0; i < N_ALIAS; i++) begin
      adr    = vga_mem_pkg::cpu_adr_t'($urandom) & 16'h7fff;
      d_late = vga_mem_pkg::bus_dat_t'($urandom);
      cpu_write(adr, 2'b11, vga_mem_pkg::bus_dat_t'($urandom));
      cpu_write(adr | 16'h8000, 2'b11, d_late);
      cpu_access(adr, 2'b11, 1'b0, '0, rdat);
      check_word($sformatf("bit16_aliasing %0d", i), d_late, rdat);
      read_and_check($sformatf("bit16_aliasing %0d high", i), adr | 16'h8000);
    end
  endtask

  task automatic scanline_fetch();
    fill_region(LINE_A_BASE, LINE_A_LEN);
    scan_line("scanline_fetch", LINE_A_BASE, LINE_A_LEN);
  endtask

  // CPU stays clear of the bytes on screen
  task automatic scan_during_cpu_traffic();
    vga_mem_pkg::cpu_adr_t adr;
    fill_region(LINE_B_BASE, LINE_B_LEN);
    fork
      scan_line("scan_during_cpu_traffic", LINE_B_BASE, LINE_B_LEN);
      begin
        for (int i = 0; i < N_MIXED; i++) begin
          adr = vga_mem_pkg::cpu_adr_t'(MIXED_WORD + i);
          cpu_write(adr, 2'b11, vga_mem_pkg::bus_dat_t'($urandom));
          read_and_check($sformatf("cpu_traffic write %0d", i), adr);
          adr = vga_mem_pkg::cpu_adr_t'((LINE_B_BASE >> 1) + i);
          read_and_check($sformatf("cpu_traffic screen read %0d", i), adr);
        end
      end
    join
  endtask

  // Watchdog sized from the test lengths
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < CYCLE_LIMIT) begin
      @(posedge wb_clk_i);
      cycle_cnt++;
    end
    $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    seed_val     = $urandom(32'h15cc);
    checks       = 0;
    value_errs   = 0;
    other_errs   = 0;
    rst_i        = 1'b1;
    wbs_adr_i    = '0;
    wbs_sel_i    = '0;
    wbs_we_i     = 1'b0;
    wbs_dat_i    = '0;
    wbs_stb_i    = 1'b0;
    line_start_i = 1'b0;
    line_base_i  = '0;
    line_len_i   = '0;
    pix_rdy_i    = 1'b0;
    repeat (3) @(negedge wb_clk_i);
    rst_i = 1'b0;

    idle_after_reset();
    word_readback();
    partial_write_lanes();
    bit16_aliasing();
    scanline_fetch();
    scan_during_cpu_traffic();
    repeat (2) @(negedge wb_clk_i);

    $display("Checks %0d, value errors %0d, other errors %0d", checks, value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: bench/vga_mem_sva.sv
module vga_mem_sva (
  input logic              wb_clk_i,
  input logic              rst_i,
  input logic              c4_stb_i,
  input logic              c4_ack_i,
  input logic              sf_stb_i,
  input logic              sf_ack_i,
  input logic              mem_stb_i,
  input logic              mem_ack_i,
  input vga_mem_pkg::pix_t pix_dat_i,
  input logic              pix_vld_i,
  input logic              pix_rdy_i
);

  // SRAM response reaches exactly one master, and that master is still asking
  one_owner_ack: assert property (@(posedge wb_clk_i) disable iff (rst_i)
    mem_ack_i |-> $onehot({c4_ack_i && c4_stb_i, sf_ack_i && sf_stb_i}))
    else $error("SRAM ack not routed to exactly one requesting master");

  // Request to the SRAM stays up until served
  mem_stb_hold: assert property (@(posedge wb_clk_i) disable iff (rst_i)
    mem_stb_i && !mem_ack_i |=> mem_stb_i)
    else $error("SRAM stb dropped before ack");

  // Offered pixel waits unchanged for the display
  pix_hold: assert property (@(posedge wb_clk_i) disable iff (rst_i)
    pix_vld_i && !pix_rdy_i |=> pix_vld_i && $stable(pix_dat_i))
    else $error("pix_vld_o or pix_dat_o changed before pix_rdy_i");

endmodule

bind vga_mem_top vga_mem_sva u_vga_mem_sva (
  .wb_clk_i  (wb_clk_i),
  .rst_i     (rst_i),
  .c4_stb_i  (c4_stb),
  .c4_ack_i  (c4_ack),
  .sf_stb_i  (sf_stb),
  .sf_ack_i  (sf_ack),
  .mem_stb_i (mem_stb),
  .mem_ack_i (mem_ack),
  .pix_dat_i (pix_dat_o),
  .pix_vld_i (pix_vld_o),
  .pix_rdy_i (pix_rdy_i)
);

// File: hdl/vga_mem_top.sv
module vga_mem_top (
  input  logic                   wb_clk_i,
  input  logic                   rst_i,
  // CPU Wishbone slave
  input  vga_mem_pkg::cpu_adr_t  wbs_adr_i,
  input  vga_mem_pkg::bus_sel_t  wbs_sel_i,
  input  logic                   wbs_we_i,
  input  vga_mem_pkg::bus_dat_t  wbs_dat_i,
  input  logic                   wbs_stb_i,
  output vga_mem_pkg::bus_dat_t  wbs_dat_o,
  output logic                   wbs_ack_o,
  // Scanline control and pixel stream
  input  logic                   line_start_i,
  input  vga_mem_pkg::cpu_adr_t  line_base_i,
  input  vga_mem_pkg::line_len_t line_len_i,
  output vga_mem_pkg::pix_t      pix_dat_o,
  output logic                   pix_vld_o,
  input  logic                   pix_rdy_i,
  output logic                   busy_o
);

  // Chain-4 master to arbiter
  vga_mem_pkg::sram_adr_t c4_adr;
  vga_mem_pkg::bus_sel_t  c4_sel;
  logic                   c4_we;
  vga_mem_pkg::bus_dat_t  c4_dat_w;
  logic                   c4_stb;
  vga_mem_pkg::bus_dat_t  c4_dat_r;
  logic                   c4_ack;
  // Fetcher to arbiter
  vga_mem_pkg::sram_adr_t sf_adr;
  logic                   sf_stb;
  vga_mem_pkg::bus_dat_t  sf_dat_r;
  logic                   sf_ack;
  // Arbiter to SRAM
  vga_mem_pkg::sram_adr_t mem_adr;
  vga_mem_pkg::bus_sel_t  mem_sel;
  logic                   mem_we;
  vga_mem_pkg::bus_dat_t  mem_dat_w;
  logic                   mem_stb;
  vga_mem_pkg::bus_dat_t  mem_dat_r;
  logic                   mem_ack;

  vga_c4_iface u_vga_c4_iface (
    .wb_clk_i  (wb_clk_i),
    .rst_i     (rst_i),
    .wbs_adr_i (wbs_adr_i),
    .wbs_sel_i (wbs_sel_i),
    .wbs_we_i  (wbs_we_i),
    .wbs_dat_i (wbs_dat_i),
    .wbs_stb_i (wbs_stb_i),
    .wbs_dat_o (wbs_dat_o),
    .wbs_ack_o (wbs_ack_o),
    .wbm_adr_o (c4_adr),
    .wbm_sel_o (c4_sel),
    .wbm_we_o  (c4_we),
    .wbm_dat_o (c4_dat_w),
    .wbm_stb_o (c4_stb),
    .wbm_dat_i (c4_dat_r),
    .wbm_ack_i (c4_ack)
  );

  vga_scan_fetch u_vga_scan_fetch (
    .wb_clk_i     (wb_clk_i),
    .rst_i        (rst_i),
    .line_start_i (line_start_i),
    .line_base_i  (line_base_i),
    .line_len_i   (line_len_i),
    .wbm_adr_o    (sf_adr),
    .wbm_stb_o    (sf_stb),
    .wbm_dat_i    (sf_dat_r),
    .wbm_ack_i    (sf_ack),
    .pix_dat_o    (pix_dat_o),
    .pix_vld_o    (pix_vld_o),
    .pix_rdy_i    (pix_rdy_i),
    .busy_o       (busy_o)
  );

  vga_mem_arbiter u_vga_mem_arbiter (
    .wb_clk_i  (wb_clk_i),
    .rst_i     (rst_i),
    .c4_adr_i  (c4_adr),
    .c4_sel_i  (c4_sel),
    .c4_we_i   (c4_we),
    .c4_dat_i  (c4_dat_w),
    .c4_stb_i  (c4_stb),
    .c4_dat_o  (c4_dat_r),
    .c4_ack_o  (c4_ack),
    .sf_adr_i  (sf_adr),
    .sf_stb_i  (sf_stb),
    .sf_dat_o  (sf_dat_r),
    .sf_ack_o  (sf_ack),
    .mem_adr_o (mem_adr),
    .mem_sel_o (mem_sel),
    .mem_we_o  (mem_we),
    .mem_dat_o (mem_dat_w),
    .mem_stb_o (mem_stb),
    .mem_dat_i (mem_dat_r),
    .mem_ack_i (mem_ack)
  );

  vga_sram u_vga_sram (
    .wb_clk_i (wb_clk_i),
    .rst_i    (rst_i),
    .adr_i    (mem_adr),
    .sel_i    (mem_sel),
    .we_i     (mem_we),
    .dat_i    (mem_dat_w),
    .stb_i    (mem_stb),
    .dat_o    (mem_dat_r),
    .ack_o    (mem_ack)
  );

endmodule

// File: hdl/vga_sram.sv
`include "vga_mem_params.svh"

module vga_sram (
  input  logic                   wb_clk_i,
  input  logic                   rst_i,
  input  vga_mem_pkg::sram_adr_t adr_i,
  input  vga_mem_pkg::bus_sel_t  sel_i,
  input  logic                   we_i,
  input  vga_mem_pkg::bus_dat_t  dat_i,
  input  logic                   stb_i,
  output vga_mem_pkg::bus_dat_t  dat_o,
  output logic                   ack_o
);

  localparam int WORDS = 2 ** `VGA_SRAM_AW;

  vga_mem_pkg::bus_dat_t mem [WORDS];
  logic                  access;

  // New cycle starts when strobe is seen and no ack is out
  assign access = stb_i & ~ack_o;

  // Single cycle ack, never back to back
  always_ff @(posedge wb_clk_i) begin
    if (rst_i) begin
      ack_o <= 1'b0;
    end else begin
      ack_o <= access;
    end
  end

  // Byte lane writes
  always_ff @(posedge wb_clk_i) begin
    if (access && we_i) begin
      if (sel_i[0]) begin
        mem[adr_i][7:0] <= dat_i[7:0];
      end
      if (sel_i[1]) begin
        mem[adr_i][15:8] <= dat_i[15:8];
      end
    end
  end

  // Read data lines up with ack
  always_ff @(posedge wb_clk_i) begin
    if (access) begin
      dat_o <= mem[adr_i];
    end
  end

endmodule

// File: hdl/vga_mem_arbiter.sv
module vga_mem_arbiter (
  input  logic                   wb_clk_i,
  input  logic                   rst_i,
  // Chain-4 CPU master
  input  vga_mem_pkg::sram_adr_t c4_adr_i,
  input  vga_mem_pkg::bus_sel_t  c4_sel_i,
  input  logic                   c4_we_i,
  input  vga_mem_pkg::bus_dat_t  c4_dat_i,
  input  logic                   c4_stb_i,
  output vga_mem_pkg::bus_dat_t  c4_dat_o,
  output logic                   c4_ack_o,
  // Scanline fetch master, read only
  input  vga_mem_pkg::sram_adr_t sf_adr_i,
  input  logic                   sf_stb_i,
  output vga_mem_pkg::bus_dat_t  sf_dat_o,
  output logic                   sf_ack_o,
  // SRAM port
  output vga_mem_pkg::sram_adr_t mem_adr_o,
  output vga_mem_pkg::bus_sel_t  mem_sel_o,
  output logic                   mem_we_o,
  output vga_mem_pkg::bus_dat_t  mem_dat_o,
  output logic                   mem_stb_o,
  input  vga_mem_pkg::bus_dat_t  mem_dat_i,
  input  logic                   mem_ack_i
);

  vga_mem_pkg::arb_gnt_e gnt_q;
  vga_mem_pkg::arb_gnt_e gnt_d;
  // Master that received the most recent ack
  vga_mem_pkg::arb_gnt_e last_q;
  logic                  cpu_own;
  logic                  owner_stb;

  assign cpu_own   = (gnt_q == vga_mem_pkg::GNT_CPU);
  assign owner_stb = cpu_own ? c4_stb_i : sf_stb_i;

  // Request mux, fetcher reads the low lane
  assign mem_adr_o = cpu_own ? c4_adr_i : sf_adr_i;
  assign mem_sel_o = cpu_own ? c4_sel_i : 2'b01;
  assign mem_we_o  = cpu_own & c4_we_i;
  assign mem_dat_o = cpu_own ? c4_dat_i : '0;
  assign mem_stb_o = owner_stb;

  // Response goes back to the owner only
  assign c4_ack_o = cpu_own & mem_ack_i;
  assign sf_ack_o = !cpu_own & mem_ack_i;
  assign c4_dat_o = cpu_own ? mem_dat_i : '0;
  assign sf_dat_o = cpu_own ? '0 : mem_dat_i;

  // Regrant only while the owner is quiet
  always_comb begin
    gnt_d = gnt_q;
    if (!owner_stb) begin
      if (c4_stb_i) begin
        gnt_d = vga_mem_pkg::GNT_CPU;
      end else if (sf_stb_i) begin
        gnt_d = vga_mem_pkg::GNT_SCAN;
      end else begin
        // Idle bus parks on the master not served last so it wins the next tie
        gnt_d = (last_q == vga_mem_pkg::GNT_CPU) ? vga_mem_pkg::GNT_SCAN
                                                 : vga_mem_pkg::GNT_CPU;
      end
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (rst_i) begin
      gnt_q  <= vga_mem_pkg::GNT_CPU;
      last_q <= vga_mem_pkg::GNT_SCAN;
    end else begin
      gnt_q <= gnt_d;
      if (mem_ack_i) begin
        last_q <= gnt_q;
      end
    end
  end

endmodule

// File: hdl/vga_scan_fetch.sv
`include "vga_mem_params.svh"

module vga_scan_fetch (
  input  logic                   wb_clk_i,
  input  logic                   rst_i,
  input  logic                   line_start_i,
  input  vga_mem_pkg::cpu_adr_t  line_base_i,
  input  vga_mem_pkg::line_len_t line_len_i,
  output vga_mem_pkg::sram_adr_t wbm_adr_o,
  output logic                   wbm_stb_o,
  input  vga_mem_pkg::bus_dat_t  wbm_dat_i,
  input  logic                   wbm_ack_i,
  output vga_mem_pkg::pix_t      pix_dat_o,
  output logic                   pix_vld_o,
  input  logic                   pix_rdy_i,
  output logic                   busy_o
);

  localparam int DEPTH = `VGA_FETCH_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  vga_mem_pkg::fetch_state_e state_q;
  vga_mem_pkg::cpu_adr_t     fetch_adr_q;
  vga_mem_pkg::line_len_t    len_q;
  vga_mem_pkg::line_len_t    issued_q;
  vga_mem_pkg::line_len_t    delivered_q;
  vga_mem_pkg::pix_t         fifo_q [DEPTH];
  logic [PTR_W-1:0]          wr_ptr_q;
  logic [PTR_W-1:0]          rd_ptr_q;
  logic [CNT_W-1:0]          fill_q;
  logic [CNT_W-1:0]          credits;
  logic                      push;
  logic                      pop;
  logic                      issue;
  logic                      last_pop;

  assign push = wbm_stb_o & wbm_ack_i;
  assign pop  = pix_vld_o & pix_rdy_i;

  // Free FIFO slots minus the read still in flight
  assign credits = CNT_W'(DEPTH) - fill_q - CNT_W'(wbm_stb_o);

  // One read at a time, only while a slot is reserved for it
  assign issue = (state_q == vga_mem_pkg::FETCH_RUN) && !wbm_stb_o &&
                 (issued_q != len_q) && (credits != '0);
  assign last_pop = pop && (delivered_q == len_q - 1'b1);

  // Pixel k sits in the low byte of word 2*(base+k)
  assign wbm_adr_o = {fetch_adr_q, 1'b0};
  assign pix_vld_o = (fill_q != '0);
  assign pix_dat_o = fifo_q[rd_ptr_q];
  assign busy_o    = (state_q == vga_mem_pkg::FETCH_RUN);

  always_ff @(posedge wb_clk_i) begin
    if (rst_i) begin
      state_q     <= vga_mem_pkg::FETCH_IDLE;
      wbm_stb_o   <= 1'b0;
      issued_q    <= '0;
      delivered_q <= '0;
    end else begin
      case (state_q)
        vga_mem_pkg::FETCH_IDLE: begin
          // Empty lines never leave idle
          if (line_start_i && line_len_i != '0) begin
            state_q     <= vga_mem_pkg::FETCH_RUN;
            issued_q    <= '0;
            delivered_q <= '0;
          end
        end
        vga_mem_pkg::FETCH_RUN: begin
          if (issue) begin
            wbm_stb_o <= 1'b1;
            issued_q  <= issued_q + 1'b1;
          end else if (push) begin
            wbm_stb_o <= 1'b0;
          end
          if (pop) begin
            delivered_q <= delivered_q + 1'b1;
          end
          // Done once the display takes the final pixel
          if (last_pop) begin
            state_q <= vga_mem_pkg::FETCH_IDLE;
          end
        end
        default: state_q <= vga_mem_pkg::FETCH_IDLE;
      endcase
    end
  end

  // Line parameters and the running read address
  always_ff @(posedge wb_clk_i) begin
    if (state_q == vga_mem_pkg::FETCH_IDLE && line_start_i) begin
      fetch_adr_q <= line_base_i;
      len_q       <= line_len_i;
    end else if (push) begin
      fetch_adr_q <= fetch_adr_q + 1'b1;
    end
  end

  // Pixel FIFO pointers and fill level
  always_ff @(posedge wb_clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   fill_q <= fill_q + 1'b1;
        2'b01:   fill_q <= fill_q - 1'b1;
        default: fill_q <= fill_q;
      endcase
    end
  end

  // Only the low byte is pixel data
  always_ff @(posedge wb_clk_i) begin
    if (push) begin
      fifo_q[wr_ptr_q] <= wbm_dat_i[7:0];
    end
  end

endmodule

// File: hdl/vga_c4_iface.sv
module vga_c4_iface (
  input  logic                   wb_clk_i,
  input  logic                   rst_i,
  // CPU slave port
  input  vga_mem_pkg::cpu_adr_t  wbs_adr_i,
  input  vga_mem_pkg::bus_sel_t  wbs_sel_i,
  input  logic                   wbs_we_i,
  input  vga_mem_pkg::bus_dat_t  wbs_dat_i,
  input  logic                   wbs_stb_i,
  output vga_mem_pkg::bus_dat_t  wbs_dat_o,
  output logic                   wbs_ack_o,
  // Master port towards the arbiter
  output vga_mem_pkg::sram_adr_t wbm_adr_o,
  output vga_mem_pkg::bus_sel_t  wbm_sel_o,
  output logic                   wbm_we_o,
  output vga_mem_pkg::bus_dat_t  wbm_dat_o,
  output logic                   wbm_stb_o,
  input  vga_mem_pkg::bus_dat_t  wbm_dat_i,
  input  logic                   wbm_ack_i
);

  // Set while the high byte half is on the bus
  logic              plane_hi_q;
  // Low byte of a read, kept until the second half returns
  vga_mem_pkg::pix_t dat_low_q;
  logic              half_done;

  assign half_done = wbm_stb_o & wbm_ack_i;

  // CPU access ends with the ack of the high half
  assign wbs_ack_o = plane_hi_q & wbm_ack_i;
  assign wbs_dat_o = {wbm_dat_i[7:0], dat_low_q};

  // Byte B lands in the low byte of word 2*(B mod 64K)
  // Bit 15 of the CPU word address aliases away
  assign wbm_adr_o = {wbs_adr_i[14:0], plane_hi_q, 1'b0};

  // Both lanes written, high SRAM byte forced to zero
  assign wbm_sel_o = 2'b11;
  assign wbm_dat_o = {8'h00, plane_hi_q ? wbs_dat_i[15:8] : wbs_dat_i[7:0]};

  // Skip the write on a lane the CPU did not select
  assign wbm_we_o = wbs_we_i & (plane_hi_q ? wbs_sel_i[1] : wbs_sel_i[0]);

  // Strobe stays up across both halves so the arbiter cannot split them
  always_ff @(posedge wb_clk_i) begin
    if (rst_i) begin
      wbm_stb_o <= 1'b0;
    end else if (wbm_stb_o) begin
      wbm_stb_o <= ~wbs_ack_o;
    end else begin
      wbm_stb_o <= wbs_stb_i;
    end
  end

  // Walk low half then high half
  always_ff @(posedge wb_clk_i) begin
    if (rst_i) begin
      plane_hi_q <= 1'b0;
    end else if (half_done) begin
      plane_hi_q <= ~plane_hi_q;
    end
  end

  // Capture the low byte on the first ack
  always_ff @(posedge wb_clk_i) begin
    if (half_done && !plane_hi_q) begin
      dat_low_q <= wbm_dat_i[7:0];
    end
  end

endmodule

// File: hdl/vga_mem_pkg.sv
package vga_mem_pkg;

  `include "vga_mem_params.svh"

  // CPU side word address, byte lane carried by sel
  typedef logic [15:0] cpu_adr_t;

  // SRAM word address
  typedef logic [`VGA_SRAM_AW-1:0] sram_adr_t;

  // Bus data and byte selects
  typedef logic [15:0] bus_dat_t;
  typedef logic [1:0]  bus_sel_t;

  // One chain-4 pixel
  typedef logic [7:0] pix_t;

  // Pixels per scanline
  typedef logic [`VGA_LINE_LEN_W-1:0] line_len_t;

  // Current owner of the SRAM port
  typedef enum logic {
    GNT_CPU,
    GNT_SCAN
  } arb_gnt_e;

  // Fetcher control
  typedef enum logic {
    FETCH_IDLE,
    FETCH_RUN
  } fetch_state_e;

endpackage

// File: hdl/vga_mem_params.svh
`ifndef VGA_MEM_PARAMS_SVH
`define VGA_MEM_PARAMS_SVH

// Pixel FIFO entries in the scanline fetcher
`define VGA_FETCH_DEPTH 4

// SRAM word address bits, 128K words of 16 bits
`define VGA_SRAM_AW 17

// Pixel count width, up to 1023 pixels per line
`define VGA_LINE_LEN_W 10

`endif
